/* flist.f */
+incdir+rtl
rtl/ifu_pkg.sv
rtl/redirect_if.sv
rtl/pc_gen.sv
rtl/inst_legal_check.sv
rtl/bus_pacer.sv
rtl/fetch_ctrl.sv
rtl/ifu_top.sv
bench/ifu_tb_clock.sv
bench/ifu_properties.sv
bench/ifu_tb.sv

/* Makefile */
# Verilator flow for the instruction fetch unit

VERILATOR ?= verilator
TOP       ?= ifu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
LINT_OPTS ?= --lint-only -Wall --timing
SIM_OPTS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(SIM_OPTS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/ifu_tb.sv */
// Instruction fetch unit testbench
// plays the instruction memory with random back-pressure, finishes
// each instruction with random redirects and checks every fetch
// against a reference model of pc sequencing and legality

`timescale 1ns/1ns

module ifu_tb;
	import ifu_pkg::*;

	localparam int          NUM_INST    = 2000;
	localparam int unsigned TIMEOUT     = 200;
	localparam inst_t       ECALL_WORD  = 32'h0000_0073;
	localparam inst_t       EBREAK_WORD = 32'h0010_0073;
	localparam inst_t       MRET_WORD   = 32'h3020_0073;
	localparam opcode_t     OP_LIST [10] = '{LUI, AUIPC, JAL, JALR, BRANCH,
		LOAD, STORE, OP_IMM, OP, SYSTEM};

	logic        clk;
	logic        rst;
	logic        branch_taken;
	addr_t       branch_target;
	logic        jmp;
	addr_t       jmp_target;
	logic        csr_jmp;
	addr_t       csr_pc;
	logic        finish;
	addr_t       araddr;
	logic        arvalid;
	logic        arready;
	inst_t       rdata;
	resp_t       rresp;
	logic        rvalid;
	logic        rready;
	logic        inst_valid;
	inst_t       inst;
	addr_t       pc;
	logic        illegal;
	logic        bus_err;
	logic [31:0] rng_state;
	addr_t       model_pc;
	int          r_hs_count  = 0;
	int          pulse_count = 0;

	ifu_tb_clock clock_gen (.clk_o(clk), .rst_o(rst));

	ifu_top dut0 (
		.clk (clk), .rst (rst),
		.branch_taken_i (branch_taken), .branch_target_i (branch_target),
		.jmp_i (jmp), .jmp_target_i (jmp_target),
		.csr_jmp_i (csr_jmp), .csr_pc_i (csr_pc), .finish_i (finish),
		.araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
		.rdata_i (rdata), .rresp_i (rresp), .rvalid_i (rvalid), .rready_o (rready),
		.inst_valid_o (inst_valid), .inst_o (inst), .pc_o (pc),
		.illegal_o (illegal), .bus_err_o (bus_err)
	);

	function logic [31:0] rand_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// raw noise, an exact system word, or a real opcode with random fields
	function inst_t make_word();
		logic [31:0] sel;
		inst_t       w;
		sel = rand_next();
		w = rand_next();
		if (sel[2:0] == 3'd2) begin
			w = sel[4] ? (sel[3] ? MRET_WORD : EBREAK_WORD) : ECALL_WORD;
		end else if (sel[2:0] > 3'd2) begin
			w[6:0] = OP_LIST[sel[15:8] % 8'd10];
			if (sel[5]) w[31:25] = sel[6] ? 7'h20 : 7'h00;
		end
		return w;
	endfunction

	// about one in ten responses is an error
	function resp_t draw_resp();
		logic [31:0] r;
		r = rand_next();
		if (r[7:0] >= 8'd26) return OKAY;
		if (r[9:8] == 2'b00) return DECERR;
		return resp_t'(r[9:8]);
	endfunction

	// allowed funct3 values per opcode as a bit mask
	function automatic bit model_illegal(inst_t w);
		logic [6:0] f7;
		logic [7:0] ok3;
		f7 = w[31:25];
		case (w[6:0])
			LUI, AUIPC, JAL, OP: ok3 = 8'hff;
			JALR:   ok3 = 8'b0000_0001;
			BRANCH: ok3 = 8'b1111_0011;
			LOAD:   ok3 = 8'b0011_0111;
			STORE:  ok3 = 8'b0000_0111;
			OP_IMM: ok3 = {2'b11, (f7 == 7'h00) || (f7 == 7'h20), 3'b111, f7 == 7'h00, 1'b1};
			SYSTEM: ok3 = 8'b0000_0110;
			default: ok3 = 8'h00;
		endcase
		return !(ok3[w[14:12]] || w == ECALL_WORD || w == EBREAK_WORD || w == MRET_WORD);
	endfunction

	task automatic stop_on_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_timeout(string what);
		$display("timeout while waiting for %s", what);
		stop_on_failure();
	endtask

	task automatic compare_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic compare_inst(string name, inst_t got, inst_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic compare_flag(string name, bit got, bit exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	// arready rises after a random delay and the handshake follows on the next rising edge
	task automatic addr_phase(output addr_t addr);
		int unsigned delay;
		int unsigned waited;
		bit          done;
		delay = rand_next() % 8;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			compare_flag("rready_o", rready, 1'b0);
			arready = (waited >= delay);
			done = arvalid && arready;
			waited++;
			if (!done && waited > TIMEOUT) report_timeout("the address handshake");
		end
		addr = araddr;
	endtask

	task automatic data_phase(input inst_t word, input resp_t resp);
		int unsigned delay;
		int unsigned waited;
		bit          done;
		delay = rand_next() % 8;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			compare_flag("arvalid_o", arvalid, 1'b0);
			arready = 1'b0;
			rvalid = (waited >= delay);
			rdata = word;
			rresp = resp;
			done = rready && rvalid;
			waited++;
			if (!done && waited > TIMEOUT) report_timeout("the read data handshake");
		end
		r_hs_count++;
	endtask

	// hold off for a while and then finish with random redirects
	task automatic finish_inst();
		int unsigned delay;
		logic [31:0] r;
		delay = rand_next() % 6;
		for (int unsigned i = 0; i <= delay; i++) begin
			@(negedge clk);
			compare_flag("inst_valid_o", inst_valid, 1'b0);
			compare_flag("arvalid_o", arvalid, 1'b0);
			compare_flag("rready_o", rready, 1'b0);
		end
		r = rand_next();
		csr_jmp = (r[1:0] == 2'b00);
		jmp = (r[3:2] == 2'b00);
		branch_taken = (r[5:4] == 2'b00);
		csr_pc = rand_next() & 32'hffff_fffc;
		jmp_target = rand_next() & 32'hffff_fffc;
		branch_target = rand_next() & 32'hffff_fffc;
		finish = 1'b1;
		// later overrides win so csr has the last word
		model_pc = model_pc + 32'd4;
		if (branch_taken) model_pc = branch_target;
		if (jmp) model_pc = jmp_target;
		if (csr_jmp) model_pc = csr_pc;
		@(negedge clk);
		finish = 1'b0;
		csr_jmp = 1'b0;
		jmp = 1'b0;
		branch_taken = 1'b0;
	endtask

	always @(negedge clk) begin
		if (!rst && inst_valid) pulse_count++;
	end

	initial begin
		addr_t       addr;
		inst_t       word;
		resp_t       resp;
		int unsigned waited;
		rng_state = 32'd13693;
		branch_taken = 1'b0;
		branch_target = '0;
		jmp = 1'b0;
		jmp_target = '0;
		csr_jmp = 1'b0;
		csr_pc = '0;
		finish = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rresp = OKAY;
		rvalid = 1'b0;
		model_pc = 32'h8000_0000;
		waited = 0;
		// reset drops on a falling edge, so look for it on the rising one
		while (rst !== 1'b0) begin
			@(posedge clk);
			waited++;
			if (waited > TIMEOUT) report_timeout("reset release");
		end
		for (int n = 0; n < NUM_INST; n++) begin
			word = make_word();
			resp = draw_resp();
			addr_phase(addr);
			compare_addr("araddr_o", addr, model_pc);
			data_phase(word, resp);
			// decode strobe comes exactly one cycle after the data handshake
			@(negedge clk);
			rvalid = 1'b0;
			compare_flag("inst_valid_o", inst_valid, 1'b1);
			compare_inst("inst_o", inst, word);
			compare_addr("pc_o", pc, addr);
			compare_flag("illegal_o", illegal, model_illegal(word));
			compare_flag("bus_err_o", bus_err, resp != OKAY);
			finish_inst();
		end
		@(negedge clk);
		if (pulse_count != r_hs_count) begin
			$display("error inst_valid pulses %h read handshakes %h", pulse_count, r_hs_count);
			stop_on_failure();
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

/* bench/ifu_properties.sv */
// Protocol checks on the fetch FSM
// AXI-lite read master rules and the one-cycle decode strobe,
// attached to fetch_ctrl by bind

`timescale 1ns/1ns

module ifu_properties (
	input logic           clk,
	input logic           rst,
	input ifu_pkg::addr_t araddr_i,
	input logic           arvalid_i,
	input logic           arready_i,
	input logic           rvalid_i,
	input logic           rready_i,
	input logic           inst_valid_i
);
	// request held with the same address until accepted
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
		else $error("arvalid dropped or araddr changed before arready");

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rready_i && !rvalid_i |=> rready_i)
		else $error("rready dropped before rvalid");

	// decode sees each instruction once
	issue_pulse: assert property (@(posedge clk) disable iff (rst)
		inst_valid_i |=> !inst_valid_i)
		else $error("inst_valid high for two cycles");

	phase_excl: assert property (@(posedge clk) disable iff (rst)
		!(arvalid_i && rready_i))
		else $error("arvalid and rready high together");

endmodule

bind fetch_ctrl ifu_properties u_props (
	.clk          (clk),
	.rst          (rst),
	.araddr_i     (araddr_o),
	.arvalid_i    (arvalid_o),
	.arready_i    (arready_i),
	.rvalid_i     (rvalid_i),
	.rready_i     (rready_o),
	.inst_valid_i (inst_valid_o)
);

/* bench/ifu_tb_clock.sv */
// Testbench clock and reset
// 40 ns clock, reset held high for the first two cycles

`timescale 1ns/1ns

module ifu_tb_clock (
	output logic clk_o,
	output logic rst_o
);
	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// release on a falling edge, away from the active edge
	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

/* rtl/ifu_top.sv */
// Instruction fetch unit top level
// ties the fetch FSM to the pc generator, bus pacer and
// legality screen, with plain ports toward core and bus

`timescale 1ns/1ns

module ifu_top (
	input  logic           clk,
	input  logic           rst,
	// redirect requests from the core
	input  logic           branch_taken_i,
	input  ifu_pkg::addr_t branch_target_i,
	input  logic           jmp_i,
	input  ifu_pkg::addr_t jmp_target_i,
	input  logic           csr_jmp_i,
	input  ifu_pkg::addr_t csr_pc_i,
	input  logic           finish_i,
	// AXI-lite read master
	output ifu_pkg::addr_t araddr_o,
	output logic           arvalid_o,
	input  logic           arready_i,
	input  ifu_pkg::inst_t rdata_i,
	input  ifu_pkg::resp_t rresp_i,
	input  logic           rvalid_i,
	output logic           rready_o,
	// to decode
	output logic           inst_valid_o,
	output ifu_pkg::inst_t inst_o,
	output ifu_pkg::addr_t pc_o,
	output logic           illegal_o,
	output logic           bus_err_o
);
	import ifu_pkg::*;

	addr_t        pc;
	logic         advance;
	fetch_state_t state;
	logic         ar_go;
	logic         r_go;
	logic         illegal;

	redirect_if rd_bus ();

	assign rd_bus.branch_taken  = branch_taken_i;
	assign rd_bus.branch_target = branch_target_i;
	assign rd_bus.jmp           = jmp_i;
	assign rd_bus.jmp_target    = jmp_target_i;
	assign rd_bus.csr_jmp       = csr_jmp_i;
	assign rd_bus.csr_pc        = csr_pc_i;

	fetch_ctrl u_fetch_ctrl (
		.clk          (clk),
		.rst          (rst),
		.finish_i     (finish_i),
		.pc_i         (pc),
		.advance_o    (advance),
		.state_o      (state),
		.ar_go_i      (ar_go),
		.r_go_i       (r_go),
		.illegal_i    (illegal),
		.araddr_o     (araddr_o),
		.arvalid_o    (arvalid_o),
		.arready_i    (arready_i),
		.rdata_i      (rdata_i),
		.rresp_i      (rresp_i),
		.rvalid_i     (rvalid_i),
		.rready_o     (rready_o),
		.inst_valid_o (inst_valid_o),
		.inst_o       (inst_o),
		.pc_o         (pc_o),
		.illegal_o    (illegal_o),
		.bus_err_o    (bus_err_o)
	);

	pc_gen u_pc_gen (
		.clk       (clk),
		.rst       (rst),
		.rd        (rd_bus.dst),
		.advance_i (advance),
		.pc_o      (pc)
	);

	bus_pacer u_bus_pacer (
		.clk     (clk),
		.rst     (rst),
		.state_i (state),
		.ar_go_o (ar_go),
		.r_go_o  (r_go)
	);

	// screened straight off the read data, latched at the handshake
	inst_legal_check u_inst_legal_check (
		.inst_i    (rdata_i),
		.illegal_o (illegal)
	);

endmodule

/* rtl/fetch_ctrl.sv */
// Fetch control
// four-state fetch FSM driving an AXI-lite read master,
// captures the returned word at the data handshake and presents it
// to decode for one cycle, then waits for the finish strobe

`timescale 1ns/1ns

module fetch_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  finish_i,
	input  ifu_pkg::addr_t        pc_i,
	output logic                  advance_o,
	output ifu_pkg::fetch_state_t state_o,
	input  logic                  ar_go_i,
	input  logic                  r_go_i,
	input  logic                  illegal_i,
	// AXI-lite read channels
	output ifu_pkg::addr_t        araddr_o,
	output logic                  arvalid_o,
	input  logic                  arready_i,
	input  ifu_pkg::inst_t        rdata_i,
	input  ifu_pkg::resp_t        rresp_i,
	input  logic                  rvalid_i,
	output logic                  rready_o,
	// decode side
	output logic                  inst_valid_o,
	output ifu_pkg::inst_t        inst_o,
	output ifu_pkg::addr_t        pc_o,
	output logic                  illegal_o,
	output logic                  bus_err_o
);
	import ifu_pkg::*;

	fetch_state_t state_q;
	fetch_state_t state_d;
	logic         ar_hs;
	logic         r_hs;

	// valid and ready wait for the pacer, never for the other side
	assign arvalid_o = (state_q == FETCH_ADDR) && ar_go_i;
	assign rready_o  = (state_q == FETCH_DATA) && r_go_i;
	// pc only moves on advance, so it is stable for the whole fetch
	assign araddr_o  = pc_i;

	assign ar_hs = arvalid_o && arready_i;
	assign r_hs  = rready_o && rvalid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			FETCH_ADDR: begin
				if (ar_hs) begin
					state_d = FETCH_DATA;
				end
			end
			FETCH_DATA: begin
				if (r_hs) begin
					state_d = FETCH_ISSUE;
				end
			end
			FETCH_ISSUE: begin
				state_d = FETCH_WAIT;
			end
			FETCH_WAIT: begin
				if (finish_i) begin
					state_d = FETCH_ADDR;
				end
			end
			default: begin
				state_d = FETCH_ADDR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= FETCH_ADDR;
		end else begin
			state_q <= state_d;
		end
	end

	// error responses are not retried, just flagged
	always_ff @(posedge clk) begin
		if (r_hs) begin
			inst_o    <= rdata_i;
			pc_o      <= pc_i;
			illegal_o <= illegal_i;
			bus_err_o <= (rresp_i != OKAY);
		end
	end

	assign inst_valid_o = (state_q == FETCH_ISSUE);
	assign advance_o    = (state_q == FETCH_WAIT) && finish_i;
	assign state_o      = state_q;

endmodule

/* rtl/bus_pacer.sv */
// Bus pacer
// draws a random delay from a 4-bit LFSR on entry to each bus phase
// and raises that phase's go level once the delay has run out

`timescale 1ns/1ns
`include "ifu_defines.svh"

module bus_pacer (
	input  logic                  clk,
	input  logic                  rst,
	input  ifu_pkg::fetch_state_t state_i,
	output logic                  ar_go_o,
	output logic                  r_go_o
);
	import ifu_pkg::*;

	logic [`IFU_DELAY_BITS-1:0] lfsr_q;
	logic [`IFU_DELAY_BITS-1:0] target_q;
	logic [`IFU_DELAY_BITS-1:0] count_q;
	logic [`IFU_DELAY_BITS-1:0] cur_target;
	logic [`IFU_DELAY_BITS-1:0] cur_count;
	fetch_state_t               prev_q;
	logic                       entry;
	logic                       expired;

	// state change means a new phase starts this cycle
	assign entry      = (state_i != prev_q);
	assign cur_target = entry ? lfsr_q : target_q;
	assign cur_count  = entry ? '0 : count_q;
	assign expired    = (cur_count == cur_target);

	always_ff @(posedge clk) begin
		if (rst) begin
			// x^4 + x^3 + 1, period 15
			lfsr_q   <= `IFU_LFSR_SEED;
			target_q <= '0;
			count_q  <= '0;
			// makes the first cycle out of reset count as an entry
			prev_q   <= FETCH_WAIT;
		end else begin
			lfsr_q   <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
			target_q <= cur_target;
			// saturate at the target
			count_q  <= expired ? cur_count : cur_count + 1'b1;
			prev_q   <= state_i;
		end
	end

	assign ar_go_o = expired && (state_i == FETCH_ADDR);
	assign r_go_o  = expired && (state_i == FETCH_DATA);

endmodule

/* rtl/inst_legal_check.sv */
// Instruction legality screen
// flags any fetched word outside the supported RV32I subset,
// pure combinational, no decode beyond the screen

`timescale 1ns/1ns

module inst_legal_check (
	input  ifu_pkg::inst_t inst_i,
	output logic           illegal_o
);
	import ifu_pkg::*;

	// fixed system words
	localparam inst_t ECALL  = 32'h0000_0073;
	localparam inst_t EBREAK = 32'h0010_0073;
	localparam inst_t MRET   = 32'h3020_0073;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;

	assign opcode = opcode_t'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	always_comb begin
		legal = 1'b0;
		case (opcode)
			LUI, AUIPC, JAL: begin
				legal = 1'b1;
			end
			JALR: begin
				legal = (funct3 == 3'd0);
			end
			// funct3 2 and 3 are unused in the branch space
			BRANCH: begin
				legal = (funct3 != 3'd2) && (funct3 != 3'd3);
			end
			LOAD: begin
				legal = (funct3 == 3'd0) || (funct3 == 3'd1) || (funct3 == 3'd2) ||
					(funct3 == 3'd4) || (funct3 == 3'd5);
			end
			STORE: begin
				legal = (funct3 == 3'd0) || (funct3 == 3'd1) || (funct3 == 3'd2);
			end
			OP_IMM: begin
				case (funct3)
					// slli
					3'd1: legal = (funct7 == 7'h00);
					// srli or srai
					3'd5: legal = (funct7 == 7'h00) || (funct7 == 7'h20);
					default: legal = 1'b1;
				endcase
			end
			OP: begin
				legal = 1'b1;
			end
			// only csrrw and csrrs, plus the exact trap words
			SYSTEM: begin
				legal = (funct3 == 3'd1) || (funct3 == 3'd2) ||
					(inst_i == ECALL) || (inst_i == EBREAK) || (inst_i == MRET);
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign illegal_o = ~legal;

endmodule

/* rtl/pc_gen.sv */
// Program counter
// holds the fetch pc and loads the next one when the current
// instruction finishes, choosing by priority
//   csr/trap jump, jump, taken branch, pc + 4

`timescale 1ns/1ns
`include "ifu_defines.svh"

module pc_gen (
	input  logic           clk,
	input  logic           rst,
	redirect_if.dst        rd,
	input  logic           advance_i,
	output ifu_pkg::addr_t pc_o
);
	import ifu_pkg::*;

	addr_t pc_q;
	addr_t pc_plus_4;
	addr_t pc_next;

	assign pc_plus_4 = pc_q + addr_t'(4);

	// trap return beats everything else
	always_comb begin
		if (rd.csr_jmp) begin
			pc_next = rd.csr_pc;
		end else if (rd.jmp) begin
			pc_next = rd.jmp_target;
		end else if (rd.branch_taken) begin
			pc_next = rd.branch_target;
		end else begin
			pc_next = pc_plus_4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `IFU_RESET_PC;
		end else if (advance_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

/* rtl/redirect_if.sv */
// Redirect bundle from the core to the pc generator
// plain levels, sampled only when the fetch FSM advances

`timescale 1ns/1ns

interface redirect_if;
	import ifu_pkg::*;

	logic  branch_taken;
	addr_t branch_target;
	logic  jmp;
	addr_t jmp_target;
	logic  csr_jmp;
	addr_t csr_pc;

	// driven from the top level input ports
	modport src (
		output branch_taken, branch_target, jmp, jmp_target, csr_jmp, csr_pc
	);

	// read by the pc generator
	modport dst (
		input branch_taken, branch_target, jmp, jmp_target, csr_jmp, csr_pc
	);

endinterface

/* rtl/ifu_pkg.sv */
// Instruction fetch unit types
// address and instruction words, AXI read response codes,
// fetch FSM states and the RV32I major opcodes

`include "ifu_defines.svh"

package ifu_pkg;

	// byte address on the read bus
	typedef logic [`IFU_XLEN-1:0] addr_t;

	// raw instruction word
	typedef logic [`IFU_XLEN-1:0] inst_t;

	// AXI read response
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_t;

	// fetch FSM, one pass per instruction
	typedef enum logic [1:0] {
		FETCH_ADDR  = 2'b00,
		FETCH_DATA  = 2'b01,
		FETCH_ISSUE = 2'b10,
		FETCH_WAIT  = 2'b11
	} fetch_state_t;

	// major opcodes of the supported subset, inst[6:0]
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		SYSTEM = 7'b1110011
	} opcode_t;

endpackage

/* rtl/ifu_defines.svh */
// Instruction fetch unit constants
// reset pc, bus widths and the pacing LFSR setup shared by the RTL
// and the testbench

`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// first fetch address out of reset
`define IFU_RESET_PC 32'h8000_0000

// address and instruction width
`define IFU_XLEN 32

// width of the random pacing delay, 0 to 15 cycles
`define IFU_DELAY_BITS 4

// LFSR start value, must not be zero
`define IFU_LFSR_SEED 4'd1

`endif
